// File: rtl/bk_settings.svh
/*
  Backup RAM sizing
  Console RAM size and byte address width, SD image sector count,
  sector buffer word width and buffer address widths
*/
`ifndef BK_SETTINGS_SVH
`define BK_SETTINGS_SVH

// Console side battery RAM
`define BK_RAM_BYTES   8192
`define BK_RAM_ABITS   13           // Byte address

// SD image, 512 byte sectors
`define BK_SECTORS     16
`define BK_LBA_BITS    4
`define BK_BUF_ABITS   8            // 256 words per sector
`define BK_DATA_BITS   16

// Word address into the RAM from the SD side
`define BK_WORD_ABITS  (`BK_LBA_BITS + `BK_BUF_ABITS)

`endif

// File: rtl/bk_pkg.sv
/*
  Backup RAM types
  Buffer word with raw and byte views, controller state encoding
*/
`include "bk_settings.svh"

package bk_pkg;

	// Byte view of one buffer word
	typedef struct packed {
		logic [7:0] hi;             // Odd console address
		logic [7:0] lo;             // Even console address
	} bk_bytes_t;

	// SD side uses raw, console side uses bytes
	typedef union packed {
		logic [`BK_DATA_BITS-1:0] raw;
		bk_bytes_t                bytes;
	} bk_word_t;

	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		REQ       = 2'd1,           // sd_rd or sd_wr held, waiting for ack
		WAIT_DONE = 2'd2            // Host streaming the sector
	} bk_state_t;

endpackage

// File: rtl/sector_counter.sv
/*
  Sector counter
  Sector index for sd_lba, ack falling edge detect, last sector flag
*/
`timescale 1ns/1ps
`include "bk_settings.svh"

module sector_counter (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    sd_ack,
	input  logic                    sector_clear,
	input  logic                    sector_step,
	output logic [`BK_LBA_BITS-1:0] sd_lba,
	output logic                    sector_done,
	output logic                    last_sector
);

	logic ack_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_lba <= '0;
			ack_d  <= 1'b0;
		end else begin
			ack_d <= sd_ack;
			if (sector_clear)
				sd_lba <= '0;
			else if (sector_step)
				sd_lba <= sd_lba + 1'b1;
		end
	end

	// Host lets go of ack once the sector is through
	assign sector_done = ack_d & ~sd_ack;
	assign last_sector = (sd_lba == `BK_LBA_BITS'(`BK_SECTORS - 1));

	a_step_clear: assert property (@(posedge clk_sys) disable iff (reset)
		!(sector_step && sector_clear))
		else $error("sector step and clear in the same cycle");

endmodule

// File: rtl/backup_ram.sv
/*
  Backup RAM storage
  8 KB dual port RAM, byte port for the console,
  16 bit word port for the SD sector buffer
*/
`timescale 1ns/1ps
`include "bk_settings.svh"

module backup_ram (
	input  logic                      clk_sys,
	input  logic [`BK_RAM_ABITS-1:0]  ram_addr,
	input  logic [7:0]                ram_wdata,
	input  logic                      ram_we,
	output logic [7:0]                ram_rdata,
	input  logic [`BK_WORD_ABITS-1:0] buf_addr,
	input  bk_pkg::bk_word_t          buf_wdata,
	input  logic                      buf_we,
	output bk_pkg::bk_word_t          buf_rdata
);
	import bk_pkg::*;

	localparam int WORDS = `BK_RAM_BYTES / 2;

	bk_word_t                  mem [WORDS];
	logic [`BK_WORD_ABITS-1:0] byte_word;      // Word holding the console byte
	bk_word_t                  byte_q;
	logic                      hi_q;

	assign byte_word = ram_addr[`BK_RAM_ABITS-1:1];

	always_ff @(posedge clk_sys) begin
		if (buf_we)
			mem[buf_addr] <= buf_wdata;
		if (ram_we) begin
			if (ram_addr[0])
				mem[byte_word].bytes.hi <= ram_wdata;  // Odd byte
			else
				mem[byte_word].bytes.lo <= ram_wdata;
		end

		buf_rdata <= mem[buf_addr];
		byte_q    <= mem[byte_word];
		hi_q      <= ram_addr[0];
	end

	assign ram_rdata = hi_q ? byte_q.bytes.hi : byte_q.bytes.lo;

	// Console must not touch the RAM word the host is writing
	a_port_clash: assert property (@(posedge clk_sys)
		!(ram_we && buf_we && (byte_word == buf_addr)))
		else $error("byte and word port write the same word");

endmodule

// File: rtl/save_tracker.sv
/*
  Save tracker
  Transfer enable from the image mount window,
  pending save flag from console writes
*/
`timescale 1ns/1ps

module save_tracker (
	input  logic clk_sys,
	input  logic reset,
	input  logic save_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic ram_we,
	input  logic bk_busy,
	output logic bk_ena,
	output logic sav_pending
);

	logic dl_d;
	logic we_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_d        <= 1'b0;
			we_d        <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			dl_d <= save_download;
			we_d <= ram_we;

			// New mount window, forget the old image
			if (save_download & ~dl_d)
				bk_ena <= 1'b0;
			if (save_download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;                  // Writable image present

			if (ram_we & ~we_d)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;             // Transfer in progress covers it
		end
	end

endmodule

// File: rtl/bk_fsm.sv
/*
  Backup RAM transfer controller
  Trigger edge detection for load and save, sector request FSM,
  busy and reload flags, sector counter control
*/
`timescale 1ns/1ps

module bk_fsm (
	input  logic clk_sys,
	input  logic reset,
	input  logic bk_load,
	input  logic bk_save,
	input  logic autosave,
	input  logic osd_status,
	input  logic save_download,
	input  logic bk_ena,
	input  logic sav_pending,
	input  logic sd_ack,
	input  logic sector_done,
	input  logic last_sector,
	output logic sd_rd,
	output logic sd_wr,
	output logic bk_busy,
	output logic bk_reload,
	output logic sector_clear,
	output logic sector_step
);
	import bk_pkg::*;

	bk_state_t state;
	logic      loading;             // Direction of the current transfer
	logic      load_d, load_dd;
	logic      save_d, save_dd;
	logic      osd_d, osd_dd;
	logic      dl_d, dl_dd;
	logic      load_rise, save_rise, osd_rise, dl_fall;
	logic      start_load, start_save;

	//////////////////////////////////////////////////
	// Trigger edges
	//////////////////////////////////////////////////
	assign load_rise = load_d & ~load_dd;
	assign save_rise = save_d & ~save_dd;
	assign osd_rise  = osd_d & ~osd_dd;    // Menu opened
	assign dl_fall   = dl_dd & ~dl_d;      // End of mount window

	assign start_load = bk_ena & (load_rise | dl_fall);
	assign start_save = bk_ena & (save_rise | (osd_rise & autosave & sav_pending));

	//////////////////////////////////////////////////
	// Transfer control
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{load_d, load_dd, save_d, save_dd} <= '0;
			{osd_d, osd_dd, dl_d, dl_dd}       <= '0;
			state     <= IDLE;
			loading   <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			bk_reload <= 1'b0;
		end else begin
			{load_dd, load_d} <= {load_d, bk_load};
			{save_dd, save_d} <= {save_d, bk_save};
			{osd_dd, osd_d}   <= {osd_d, osd_status};
			{dl_dd, dl_d}     <= {dl_d, save_download};

			case (state)
				IDLE: begin
					if (start_load) begin          // Load wins over save
						state     <= REQ;
						loading   <= 1'b1;
						sd_rd     <= 1'b1;
						bk_reload <= load_rise;        // Only a user load reloads
					end else if (start_save) begin
						state   <= REQ;
						loading <= 1'b0;
						sd_wr   <= 1'b1;
					end
				end
				REQ: begin
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= WAIT_DONE;
					end
				end
				WAIT_DONE: begin
					if (sector_done) begin
						if (last_sector) begin
							state     <= IDLE;
							bk_reload <= 1'b0;
						end else begin
							state <= REQ;              // Counter steps on this edge too
							sd_rd <= loading;
							sd_wr <= ~loading;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bk_busy      = (state != IDLE);
	assign sector_clear = (state == IDLE);  // Every transfer starts at sector 0
	assign sector_step  = (state == WAIT_DONE) & sector_done & ~last_sector;

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	a_no_idle_req: assert property (@(posedge clk_sys) disable iff (reset)
		(state == IDLE) |-> !(sd_rd || sd_wr))
		else $error("request raised while idle");

endmodule

// File: rtl/bram_backup.sv
/*
  Backup RAM save and load top level
  Transfer FSM, sector counter, dual port RAM and save tracker
  between the console byte port and the SD sector buffer
*/
`timescale 1ns/1ps
`include "bk_settings.svh"

module bram_backup (
	input  logic                     clk_sys,
	input  logic                     reset,
	// Console byte port
	input  logic [`BK_RAM_ABITS-1:0] ram_addr,
	input  logic [7:0]               ram_wdata,
	input  logic                     ram_we,
	output logic [7:0]               ram_rdata,
	// Image mount and menu controls
	input  logic                     save_download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     bk_load,
	input  logic                     bk_save,
	input  logic                     autosave,
	input  logic                     osd_status,
	// SD host
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic [`BK_LBA_BITS-1:0]  sd_lba,
	input  logic                     sd_ack,
	input  logic [`BK_BUF_ABITS-1:0] sd_buff_addr,
	input  logic [`BK_DATA_BITS-1:0] sd_buff_dout,
	output logic [`BK_DATA_BITS-1:0] sd_buff_din,
	input  logic                     sd_buff_wr,
	// Status
	output logic                     bk_busy,
	output logic                     bk_reload,
	output logic                     sav_pending
);
	import bk_pkg::*;

	logic     bk_ena;
	logic     sector_done, last_sector;
	logic     sector_clear, sector_step;
	bk_word_t buf_wdata, buf_rdata;

	//////////////////////////////////////////////////
	// SD buffer side
	//////////////////////////////////////////////////
	assign buf_wdata.raw = sd_buff_dout;
	assign sd_buff_din   = buf_rdata.raw;

	bk_fsm u_fsm (
		.clk_sys, .reset, .bk_load, .bk_save, .autosave, .osd_status,
		.save_download, .bk_ena, .sav_pending, .sd_ack, .sector_done,
		.last_sector, .sd_rd, .sd_wr, .bk_busy, .bk_reload,
		.sector_clear, .sector_step
	);

	sector_counter u_sector (
		.clk_sys, .reset, .sd_ack, .sector_clear, .sector_step,
		.sd_lba, .sector_done, .last_sector
	);

	backup_ram u_ram (
		.clk_sys,
		.ram_addr, .ram_wdata, .ram_we, .ram_rdata,
		.buf_addr  ({sd_lba, sd_buff_addr}),    // Sector, word in sector
		.buf_wdata (buf_wdata),
		.buf_we    (sd_buff_wr & sd_ack),
		.buf_rdata (buf_rdata)
	);

	save_tracker u_tracker (
		.clk_sys, .reset, .save_download, .img_mounted, .img_readonly,
		.ram_we, .bk_busy, .bk_ena, .sav_pending
	);

endmodule

// File: bench/sd_card_model.sv
/*
  SD host model
  Answers sd_rd and sd_wr requests, streams a 4096 word image
  on a load and captures sd_buff_din one cycle late on a save
*/
`timescale 1ns/1ps
`include "bk_settings.svh"

module sd_card_model (
	input  logic                     clk_sys,
	input  logic                     sd_rd,
	input  logic                     sd_wr,
	input  logic [`BK_LBA_BITS-1:0]  sd_lba,
	output logic                     sd_ack,
	output logic [`BK_BUF_ABITS-1:0] sd_buff_addr,
	output logic [`BK_DATA_BITS-1:0] sd_buff_dout,
	input  logic [`BK_DATA_BITS-1:0] sd_buff_din,
	output logic                     sd_buff_wr
);

	logic [`BK_DATA_BITS-1:0] img [4096];  // Source for loads
	logic [`BK_DATA_BITS-1:0] cap [4096];  // Filled by saves
	integer                   base, k, delay;
	logic                     load;

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				base  = sd_lba * 256;
				load  = sd_rd;
				delay = $urandom_range(5, 0);   // Host latency
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (k = 0; k <= 256; k++) begin
					if (k < 256) begin
						sd_buff_addr = k[7:0];
						sd_buff_dout = img[base + k];
						sd_buff_wr   = load;
					end else
						sd_buff_wr = 1'b0;
					if (!load && k > 0)
						cap[base + k - 1] = sd_buff_din;  // RAM read lag
					@(negedge clk_sys);
				end
				sd_ack = 1'b0;
			end
		end
	end

endmodule

// File: bench/tb_bram_backup.sv
/*
  Testbench for the backup RAM save and load path
  Clock, reset, trigger stimulus, SD host model,
  protocol assertions and image checks
*/
`timescale 1ns/1ps

module tb_bram_backup;

	logic        clk_sys, reset, ram_we, save_download, img_mounted, img_readonly;
	logic        bk_load, bk_save, autosave, osd_status, sd_ack, sd_buff_wr;
	logic [12:0] ram_addr;
	logic [7:0]  ram_wdata, ram_rdata;
	logic [7:0]  sd_buff_addr;
	logic [15:0] sd_buff_dout, sd_buff_din;
	logic [3:0]  sd_lba, exp_lba;
	logic        sd_rd, sd_wr, bk_busy, bk_reload, sav_pending, req_q;
	logic        go, quiet, user_load;
	logic [15:0] exp_img [4096];
	integer      errors, checks, cycles, i;
	string       test_name;

	bram_backup u_dut (.*);
	sd_card_model u_sd (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == 40000) begin
			$display("Timeout after %0d cycles, a transfer never finished", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// Expected sector index, restarts with each transfer
	always @(posedge clk_sys) begin
		req_q <= sd_rd | sd_wr;
		if (reset || !bk_busy)
			exp_lba <= '0;
		else if ((sd_rd | sd_wr) & ~req_q)
			exp_lba <= exp_lba + 1'b1;
	end

	//////////////////////////////////////////////////
	// Protocol assertions
	//////////////////////////////////////////////////
	a_excl: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else begin
			errors++;
			$display("sd_rd and sd_wr were high together");
		end
	a_lba: assert property (@(posedge clk_sys) disable iff (reset)
		((sd_rd | sd_wr) & ~req_q) |-> (sd_lba == exp_lba))
		else begin
			errors++;
			$display("MISMATCH %s: expected %0d actual %0d", test_name,
				$sampled(exp_lba), $sampled(sd_lba));
		end
	a_next: assert property (@(posedge clk_sys) disable iff (reset)
		($fell(sd_ack) && bk_busy && sd_lba != 4'd15) |=> (sd_rd || sd_wr))
		else begin
			errors++;
			$display("%s: next sector not requested", test_name);
		end
	a_start: assert property (@(posedge clk_sys) disable iff (reset)
		(go && ($rose(bk_load) || $rose(bk_save) || $fell(save_download) ||
		$rose(osd_status))) |-> ##2 (sd_rd || sd_wr))
		else begin
			errors++;
			$display("%s: trigger raised no request", test_name);
		end
	a_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		quiet |-> !(sd_rd || sd_wr || bk_busy))
		else begin
			errors++;
			$display("%s: transfer started while disabled", test_name);
		end
	// Reload flag only for the whole of a user load
	a_reload: assert property (@(posedge clk_sys) disable iff (reset)
		bk_reload == (user_load && bk_busy))
		else begin
			errors++;
			$display("MISMATCH %s: expected %b actual %b", test_name,
				$sampled(user_load) & $sampled(bk_busy), $sampled(bk_reload));
		end
	a_clear: assert property (@(posedge clk_sys) disable iff (reset)
		($past(bk_busy) && bk_busy) |-> !sav_pending)
		else begin
			errors++;
			$display("%s: sav_pending not cleared while busy", test_name);
		end

	task automatic expect_val(input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (exp == act)
			else begin
				errors++;
				$display("MISMATCH %s: expected %h actual %h", test_name, exp, act);
			end
	endtask

	task automatic wait_done();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) @(negedge clk_sys);
	endtask

	task automatic write_byte(input logic [12:0] a, input logic [7:0] d);
		ram_addr  = a;
		ram_wdata = d;
		ram_we    = 1'b1;
		@(negedge clk_sys) ram_we = 1'b0;
		if (a[0])
			exp_img[a[12:1]][15:8] = d;
		else
			exp_img[a[12:1]][7:0] = d;
		@(negedge clk_sys) expect_val(16'd1, {15'd0, sav_pending});
	endtask

	task automatic check_byte(input logic [12:0] a);
		logic [15:0] w;
		w = u_sd.img[a[12:1]];             // Load source word
		ram_addr = a;
		repeat (2) @(negedge clk_sys);
		expect_val({8'd0, a[0] ? w[15:8] : w[7:0]}, {8'd0, ram_rdata});
	endtask

	task automatic mount_image(input logic ro);
		save_download = 1'b1;
		img_readonly  = ro;
		@(negedge clk_sys) img_mounted = 1'b1;
		@(negedge clk_sys) img_mounted = 1'b0;
		repeat (2) @(negedge clk_sys);
		save_download = 1'b0;               // End of window
	endtask

	task automatic compare_image();
		for (int w = 0; w < 4096; w++)
			expect_val(exp_img[w], u_sd.cap[w]);
	endtask

	initial begin
		{reset, ram_we, save_download, img_mounted, img_readonly} = 5'b10000;
		{bk_load, bk_save, autosave, osd_status} = '0;
		{ram_addr, ram_wdata, go, quiet, user_load} = '0;
		{errors, checks, cycles} = '0;
		test_name = "reset";
		void'($urandom(32'h6eb1));
		for (i = 0; i < 4096; i++) begin
			u_sd.img[i] = 16'($urandom);
			exp_img[i] = u_sd.img[i];
		end
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		expect_val(16'd0, {12'd0, sd_rd, sd_wr, bk_busy, sav_pending});
		quiet = 1'b1;
		@(negedge clk_sys) bk_save = 1'b1;
		@(negedge clk_sys) bk_save = 1'b0;
		repeat (6) @(negedge clk_sys);
		test_name = "readonly";
		mount_image(1'b1);
		@(negedge clk_sys) bk_load = 1'b1;
		@(negedge clk_sys) bk_load = 1'b0;
		repeat (6) @(negedge clk_sys);
		quiet = 1'b0;
		test_name = "load";
		go = 1'b1;
		mount_image(1'b0);
		wait_done();
		for (i = 0; i < 40; i++) check_byte(13'($urandom_range(8191, 0)));
		check_byte(13'd0);
		check_byte(13'd8191);
		// Console change then manual save
		test_name = "save";
		write_byte(13'h0155, 8'h5a);
		bk_save = 1'b1;
		@(negedge clk_sys) bk_save = 1'b0;
		wait_done();
		compare_image();
		expect_val(16'd0, {15'd0, sav_pending});
		test_name = "autosave";
		autosave = 1'b1;
		write_byte(13'h1a2a, 8'hc3);
		osd_status = 1'b1;
		@(negedge clk_sys) osd_status = 1'b0;
		wait_done();
		compare_image();
		go = 1'b0;
		quiet = 1'b1;                       // Nothing pending now
		osd_status = 1'b1;
		@(negedge clk_sys) osd_status = 1'b0;
		repeat (6) @(negedge clk_sys);
		quiet = 1'b0;
		test_name = "user load";
		{go, user_load} = 2'b11;
		bk_load = 1'b1;
		@(negedge clk_sys) bk_load = 1'b0;
		wait_done();
		user_load = 1'b0;
		check_byte(13'h0155);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/bk_pkg.sv
rtl/sector_counter.sv
rtl/backup_ram.sv
rtl/save_tracker.sv
rtl/bk_fsm.sv
rtl/bram_backup.sv
bench/sd_card_model.sv
bench/tb_bram_backup.sv

// File: Makefile
# Verilator build, run, lint and clean for the backup RAM path

TOP = tb_bram_backup

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f rtl/*.sv rtl/*.svh bench/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only -Irtl rtl/bk_pkg.sv rtl/sector_counter.sv rtl/backup_ram.sv \
		rtl/save_tracker.sv rtl/bk_fsm.sv rtl/bram_backup.sv --top-module bram_backup

clean:
	rm -rf obj_dir sim.log
